// File: verilog/map_pkg.sv
`default_nettype none

package map_pkg;

	// CPU register slot, {A14, A13, A0}
	typedef enum logic [2:0]
	{
		REG_CFG        = 3'd0, // $8000
		REG_BANK_DATA  = 3'd1, // $8001
		REG_MIRROR     = 3'd2, // $a000
		REG_RAM_CFG    = 3'd3, // $a001
		REG_RELOAD     = 3'd4, // $c000
		REG_RELOAD_REQ = 3'd5, // $c001
		REG_IRQ_OFF    = 3'd6, // $e000
		REG_IRQ_ON     = 3'd7  // $e001
	} reg_sel_e;

	// requests from the register file to the scanline counter
	typedef enum logic [2:0]
	{
		IRQ_NONE    = 3'd0,
		IRQ_RELOAD  = 3'd1,
		IRQ_DISABLE = 3'd2,
		IRQ_ENABLE  = 3'd3,
		IRQ_SS_LOAD = 3'd4
	} irq_cmd_e;

	typedef logic [7:0]  bank_t;
	typedef logic [5:0]  prg_bank_t; // 8 KB units
	typedef logic [18:0] prg_addr_t; // 512 KB PRG space
	typedef logic [17:0] chr_addr_t; // 256 KB CHR space

	// R0..R5 then R6, R7
	localparam bank_t BANK_RESET [0:7] = '{
		8'd0,
		8'd2,
		8'd4,
		8'd5,
		8'd6,
		8'd7,
		8'd0,
		8'd1
	};

	// save-state slots past the two register blocks
	localparam bank_t SS_IRQ_CTR   = 8'd16;
	localparam bank_t SS_IRQ_FLAGS = 8'd17;
	localparam bank_t SS_MAP_IDX   = 8'd127;

	// A12 must sit low this many samples before a rise is taken
	localparam int A12_QUIET = 4;

endpackage

`default_nettype wire

// File: verilog/mmc3_regs.sv
`timescale 1ns/1ps
`default_nettype none

module mmc3_regs
#(
	parameter int MAP_IDX = 119
)
(
	input  wire                m2,
	input  wire                map_rst,
	input  wire                cfg_mir_v,
	input  wire  [14:0]        cpu_addr,
	input  map_pkg::bank_t     cpu_dat,
	input  wire                cpu_ce,
	input  wire                cpu_rw,
	input  wire                ss_act,
	input  wire                ss_we,
	input  wire  [7:0]         ss_addr,
	input  map_pkg::bank_t     irq_ctr,
	input  wire                irq_on,
	input  wire                irq_pend,
	input  wire                irq_reload_req,
	output map_pkg::bank_t     ss_rdat,
	output map_pkg::irq_cmd_e  irq_cmd,
	output map_pkg::bank_t     reload_val,
	output logic               swap_control,
	output logic               chr_invert,
	output logic               mirror_mode,
	output logic               ram_on,
	output logic               ram_we_off,
	output map_pkg::prg_bank_t prg_r6,
	output map_pkg::prg_bank_t prg_r7,
	output map_pkg::bank_t     chr_r0,
	output map_pkg::bank_t     chr_r1,
	output map_pkg::bank_t     chr_r2,
	output map_pkg::bank_t     chr_r3,
	output map_pkg::bank_t     chr_r4,
	output map_pkg::bank_t     chr_r5
);

	import map_pkg::*;

	bank_t    mmc_regs [0:7];  // last value written to each slot
	bank_t    bank_regs [0:7]; // R0..R7 behind $8001
	reg_sel_e reg_sel;
	logic     cpu_wr;

	assign reg_sel = reg_sel_e'({cpu_addr[14:13], cpu_addr[0]});
	assign cpu_wr = !cpu_ce && !cpu_rw;

	always_ff @(negedge m2)
	begin
		if (ss_act)
		begin
			if (ss_we && ss_addr[7:3] == 5'd0)
				mmc_regs[ss_addr[2:0]] <= cpu_dat;
			if (ss_we && ss_addr[7:3] == 5'd1)
				bank_regs[ss_addr[2:0]] <= cpu_dat;
		end
		else if (map_rst)
		begin
			for (int i = 0; i < 8; i++)
			begin
				mmc_regs[i] <= (i == REG_MIRROR) ? bank_t'(cfg_mir_v) : '0;
				bank_regs[i] <= BANK_RESET[i];
			end
		end
		else if (cpu_wr)
		begin
			mmc_regs[reg_sel] <= cpu_dat;
			if (reg_sel == REG_BANK_DATA)
				bank_regs[mmc_regs[REG_CFG][2:0]] <= cpu_dat; // target from $8000
		end
	end

	always_comb
	begin
		irq_cmd = IRQ_NONE;
		if (ss_act)
		begin
			if (ss_we && ss_addr == SS_IRQ_FLAGS)
				irq_cmd = IRQ_SS_LOAD;
		end
		else if (cpu_wr)
		begin
			case (reg_sel)
				REG_RELOAD_REQ: irq_cmd = IRQ_RELOAD;
				REG_IRQ_OFF:    irq_cmd = IRQ_DISABLE;
				REG_IRQ_ON:     irq_cmd = IRQ_ENABLE;
				default:        irq_cmd = IRQ_NONE;
			endcase
		end
	end

	always_comb
	begin
		if (ss_addr[7:3] == 5'd0)
			ss_rdat = mmc_regs[ss_addr[2:0]];
		else if (ss_addr[7:3] == 5'd1)
			ss_rdat = bank_regs[ss_addr[2:0]];
		else if (ss_addr == SS_IRQ_CTR)
			ss_rdat = irq_ctr;
		else if (ss_addr == SS_IRQ_FLAGS)
			ss_rdat = {3'b000, irq_on, irq_pend, 1'b0, irq_reload_req, 1'b0}; // xor pairs
		else if (ss_addr == SS_MAP_IDX)
			ss_rdat = bank_t'(MAP_IDX);
		else
			ss_rdat = 8'hff;
	end

	assign reload_val   = mmc_regs[REG_RELOAD];
	assign swap_control = mmc_regs[REG_CFG][6];
	assign chr_invert   = mmc_regs[REG_CFG][7];
	assign mirror_mode  = mmc_regs[REG_MIRROR][0];
	assign ram_on       = mmc_regs[REG_RAM_CFG][7];
	assign ram_we_off   = mmc_regs[REG_RAM_CFG][6];
	assign prg_r6       = bank_regs[6][5:0];
	assign prg_r7       = bank_regs[7][5:0];
	assign chr_r0       = bank_regs[0];
	assign chr_r1       = bank_regs[1];
	assign chr_r2       = bank_regs[2];
	assign chr_r3       = bank_regs[3];
	assign chr_r4       = bank_regs[4];
	assign chr_r5       = bank_regs[5];

	// flag restore only ever comes from the save-state port
	a_ss_load_only_in_ss: assert property (@(negedge m2) !ss_act |-> irq_cmd != IRQ_SS_LOAD);

endmodule

`default_nettype wire

// File: verilog/mmc3_prg_map.sv
`timescale 1ns/1ps
`default_nettype none

module mmc3_prg_map
(
	input  wire  [14:0]        cpu_addr,
	input  wire                cpu_ce,
	input  wire                cpu_rw,
	input  wire                swap_control,
	input  map_pkg::prg_bank_t prg_r6,
	input  map_pkg::prg_bank_t prg_r7,
	input  wire                ram_on,
	input  wire                ram_we_off,
	output map_pkg::prg_addr_t prg_addr,
	output logic               prg_oe,
	output logic               rom_ce,
	output logic               ram_ce,
	output logic               ram_we,
	output logic               map_cpu_oe
);

	import map_pkg::*;

	localparam prg_bank_t BANK_2ND_LAST = 6'h3e;
	localparam prg_bank_t BANK_LAST     = 6'h3f;

	prg_bank_t prg_bank;
	logic      ram_area;

	always_comb
	begin
		case (cpu_addr[14:13])
			2'd0:    prg_bank = swap_control ? BANK_2ND_LAST : prg_r6;
			2'd1:    prg_bank = prg_r7;
			2'd2:    prg_bank = swap_control ? prg_r6 : BANK_2ND_LAST;
			default: prg_bank = BANK_LAST;
		endcase
	end

	assign prg_addr = {cpu_ce ? 6'd0 : prg_bank, cpu_addr[12:0]};
	assign prg_oe   = cpu_rw;
	assign rom_ce   = !cpu_ce;

	assign ram_area   = cpu_ce && cpu_addr[14:13] == 2'b11; // $6000-$7fff
	assign ram_ce     = ram_area && ram_on;
	assign ram_we     = ram_ce && !cpu_rw && !ram_we_off;
	assign map_cpu_oe = ram_area && !ram_on && cpu_rw; // open bus

endmodule

`default_nettype wire

// File: verilog/mmc3_chr_map.sv
`timescale 1ns/1ps
`default_nettype none

module mmc3_chr_map
#(
	parameter int MAP_IDX = 119
)
(
	input  wire  [13:0]        ppu_addr,
	input  wire                ppu_oe,
	input  wire                ppu_we,
	input  wire                chr_invert,
	input  map_pkg::bank_t     chr_r0,
	input  map_pkg::bank_t     chr_r1,
	input  map_pkg::bank_t     chr_r2,
	input  map_pkg::bank_t     chr_r3,
	input  map_pkg::bank_t     chr_r4,
	input  map_pkg::bank_t     chr_r5,
	input  wire                mirror_mode,
	output map_pkg::chr_addr_t chr_addr,
	output logic               chr_ce,
	output logic               chr_oe,
	output logic               chr_we,
	output logic               ciram_a10,
	output logic               ciram_ce
);

	import map_pkg::*;

	// 8 KB of CHR RAM on TQROM, 2 KB on the other boards
	localparam int    RAM_BITS = (MAP_IDX == 119) ? 3 : 1;
	localparam bank_t RAM_MASK = bank_t'((1 << RAM_BITS) - 1);

	bank_t chr_bank;
	logic  chr_ram;

	always_comb
	begin
		if (ppu_addr[12:11] == {chr_invert, 1'b0})
			chr_bank = {chr_r0[7:1], ppu_addr[10]}; // 2 KB
		else if (ppu_addr[12:11] == {chr_invert, 1'b1})
			chr_bank = {chr_r1[7:1], ppu_addr[10]};
		else
		begin
			case (ppu_addr[11:10])
				2'd0:    chr_bank = chr_r2;
				2'd1:    chr_bank = chr_r3;
				2'd2:    chr_bank = chr_r4;
				default: chr_bank = chr_r5;
			endcase
		end
	end

	assign chr_ram  = chr_bank[6];
	assign chr_addr = {chr_ram ? (chr_bank & RAM_MASK) : chr_bank, ppu_addr[9:0]};

	assign chr_ce = !ppu_addr[13];
	assign chr_oe = !ppu_oe;
	assign chr_we = chr_ram && chr_ce && !ppu_we; // rom banks stay read only

	// vertical uses A10, horizontal A11
	assign ciram_a10 = mirror_mode ? ppu_addr[11] : ppu_addr[10];
	assign ciram_ce  = !ppu_addr[13];

endmodule

`default_nettype wire

// File: verilog/mmc3_irq.sv
`timescale 1ns/1ps
`default_nettype none

module mmc3_irq
(
	input  wire               m2,
	input  wire               map_rst,
	input  wire               mmc3b_mode,
	input  wire               ppu_a12,
	input  map_pkg::irq_cmd_e irq_cmd,
	input  map_pkg::bank_t    reload_val,
	input  map_pkg::bank_t    ss_dat,
	output logic              irq,
	output map_pkg::bank_t    irq_ctr,
	output logic              irq_on,
	output logic              irq_pend,
	output logic              irq_reload_req
);

	import map_pkg::*;

	logic [7:0] a12_filter; // past A12 samples, newest in bit 0
	logic       a12_rise;
	logic       irq_reload;
	logic       irq_act;

	assign a12_rise   = ppu_a12 && a12_filter[A12_QUIET-1:0] == '0;
	assign irq_reload = irq_reload_req || (mmc3b_mode && irq_ctr == 8'd0);

	// counter about to land on zero at this rise
	assign irq_act = irq_on && a12_rise &&
		((!irq_reload && irq_ctr == 8'd1) || (irq_reload && reload_val == 8'd0));

	assign irq = irq_pend || irq_act;

	always_ff @(negedge m2)
	begin
		if (ss_act_load())
		begin
			irq_reload_req <= ss_dat[1] ^ ss_dat[0];
			irq_pend       <= ss_dat[3] ^ ss_dat[2];
			irq_on         <= ss_dat[4];
		end
		else if (map_rst)
		begin
			a12_filter     <= '1; // no rise right out of reset
			irq_ctr        <= '0;
			irq_on         <= 1'b0;
			irq_pend       <= 1'b0;
			irq_reload_req <= 1'b0;
		end
		else
		begin
			a12_filter <= {a12_filter[6:0], ppu_a12};
			if (a12_rise)
			begin
				if (irq_reload || irq_ctr == 8'd0)
					irq_ctr <= reload_val;
				else
					irq_ctr <= irq_ctr - 8'd1;
				irq_reload_req <= 1'b0;
				if (irq_act)
					irq_pend <= 1'b1;
			end
			case (irq_cmd)
				IRQ_RELOAD:
					irq_reload_req <= 1'b1;
				IRQ_DISABLE:
				begin
					irq_on   <= 1'b0;
					irq_pend <= 1'b0; // acknowledge
				end
				IRQ_ENABLE:
					irq_on <= 1'b1;
				default:
					;
			endcase
		end
	end

	function automatic logic ss_act_load();
		return irq_cmd == IRQ_SS_LOAD;
	endfunction

	// outside a restore, pending only follows an enabled counter
	a_pend_needs_on: assert property (@(negedge m2)
		(irq_cmd != IRQ_SS_LOAD && !irq_on && !irq_pend) |=> !irq_pend);

endmodule

`default_nettype wire

// File: verilog/map_119.sv
`timescale 1ns/1ps
`default_nettype none

module map_119
#(
	parameter int MAP_IDX = 119
)
(
	input  wire                m2,
	input  wire                map_rst,
	input  wire                cfg_mir_v,
	input  wire                mmc3b_mode,
	input  wire  [14:0]        cpu_addr,
	input  wire  [7:0]         cpu_dat,
	input  wire                cpu_ce,
	input  wire                cpu_rw,
	input  wire  [13:0]        ppu_addr,
	input  wire                ppu_oe,
	input  wire                ppu_we,
	input  wire                ss_act,
	input  wire                ss_we,
	input  wire  [7:0]         ss_addr,
	output map_pkg::prg_addr_t prg_addr,
	output logic               prg_oe,
	output logic               rom_ce,
	output logic               ram_ce,
	output logic               ram_we,
	output logic               map_cpu_oe,
	output map_pkg::chr_addr_t chr_addr,
	output logic               chr_ce,
	output logic               chr_oe,
	output logic               chr_we,
	output logic               ciram_a10,
	output logic               ciram_ce,
	output logic               irq,
	output map_pkg::bank_t     ss_rdat
);

	import map_pkg::*;

	irq_cmd_e  irq_cmd;
	bank_t     reload_val;
	bank_t     irq_ctr;
	logic      irq_on;
	logic      irq_pend;
	logic      irq_reload_req;
	logic      swap_control;
	logic      chr_invert;
	logic      mirror_mode;
	logic      ram_on;
	logic      ram_we_off;
	prg_bank_t prg_r6;
	prg_bank_t prg_r7;
	bank_t     chr_r0;
	bank_t     chr_r1;
	bank_t     chr_r2;
	bank_t     chr_r3;
	bank_t     chr_r4;
	bank_t     chr_r5;

	mmc3_regs #(
		.MAP_IDX(MAP_IDX)
	) i_mmc3_regs (
		.m2(m2),
		.map_rst(map_rst),
		.cfg_mir_v(cfg_mir_v),
		.cpu_addr(cpu_addr),
		.cpu_dat(cpu_dat),
		.cpu_ce(cpu_ce),
		.cpu_rw(cpu_rw),
		.ss_act(ss_act),
		.ss_we(ss_we),
		.ss_addr(ss_addr),
		.irq_ctr(irq_ctr),
		.irq_on(irq_on),
		.irq_pend(irq_pend),
		.irq_reload_req(irq_reload_req),
		.ss_rdat(ss_rdat),
		.irq_cmd(irq_cmd),
		.reload_val(reload_val),
		.swap_control(swap_control),
		.chr_invert(chr_invert),
		.mirror_mode(mirror_mode),
		.ram_on(ram_on),
		.ram_we_off(ram_we_off),
		.prg_r6(prg_r6),
		.prg_r7(prg_r7),
		.chr_r0(chr_r0),
		.chr_r1(chr_r1),
		.chr_r2(chr_r2),
		.chr_r3(chr_r3),
		.chr_r4(chr_r4),
		.chr_r5(chr_r5)
	);

	mmc3_prg_map i_mmc3_prg_map (
		.cpu_addr(cpu_addr),
		.cpu_ce(cpu_ce),
		.cpu_rw(cpu_rw),
		.swap_control(swap_control),
		.prg_r6(prg_r6),
		.prg_r7(prg_r7),
		.ram_on(ram_on),
		.ram_we_off(ram_we_off),
		.prg_addr(prg_addr),
		.prg_oe(prg_oe),
		.rom_ce(rom_ce),
		.ram_ce(ram_ce),
		.ram_we(ram_we),
		.map_cpu_oe(map_cpu_oe)
	);

	mmc3_chr_map #(
		.MAP_IDX(MAP_IDX)
	) i_mmc3_chr_map (
		.ppu_addr(ppu_addr),
		.ppu_oe(ppu_oe),
		.ppu_we(ppu_we),
		.chr_invert(chr_invert),
		.chr_r0(chr_r0),
		.chr_r1(chr_r1),
		.chr_r2(chr_r2),
		.chr_r3(chr_r3),
		.chr_r4(chr_r4),
		.chr_r5(chr_r5),
		.mirror_mode(mirror_mode),
		.chr_addr(chr_addr),
		.chr_ce(chr_ce),
		.chr_oe(chr_oe),
		.chr_we(chr_we),
		.ciram_a10(ciram_a10),
		.ciram_ce(ciram_ce)
	);

	mmc3_irq i_mmc3_irq (
		.m2(m2),
		.map_rst(map_rst),
		.mmc3b_mode(mmc3b_mode),
		.ppu_a12(ppu_addr[12]),
		.irq_cmd(irq_cmd),
		.reload_val(reload_val),
		.ss_dat(cpu_dat), // restore data rides the cpu bus
		.irq(irq),
		.irq_ctr(irq_ctr),
		.irq_on(irq_on),
		.irq_pend(irq_pend),
		.irq_reload_req(irq_reload_req)
	);

endmodule

`default_nettype wire

// File: tests/tb_map_119.sv
`timescale 1ns/1ps
`default_nettype none

module tb_map_119;

	import map_pkg::*;

	localparam int MAP_IDX        = 119;
	localparam int SEED           = 42774;
	localparam int PLANNED_CYCLES = 1800; // reset, banking, ram, irq and save-state phases

	logic               m2;
	logic               map_rst;
	logic               cfg_mir_v;
	logic               mmc3b_mode;
	logic [14:0]        cpu_addr;
	logic [7:0]         cpu_dat;
	logic               cpu_ce;
	logic               cpu_rw;
	logic [13:0]        ppu_addr;
	logic               ppu_oe;
	logic               ppu_we;
	logic               ss_act;
	logic               ss_we;
	logic [7:0]         ss_addr;
	prg_addr_t          prg_addr;
	logic               prg_oe;
	logic               rom_ce;
	logic               ram_ce;
	logic               ram_we;
	logic               map_cpu_oe;
	chr_addr_t          chr_addr;
	logic               chr_ce;
	logic               chr_oe;
	logic               chr_we;
	logic               ciram_a10;
	logic               ciram_ce;
	logic               irq;
	bank_t              ss_rdat;

	// reference state
	bank_t m_regs [0:7];
	bank_t m_bank [0:7];
	bank_t m_ctr;
	logic  m_on;
	logic  m_pend;
	logic  m_req;

	int prg_errors;
	int chr_errors;
	int byte_errors;

	map_119 #(
		.MAP_IDX(MAP_IDX)
	) i_map_119 (
		.m2(m2),
		.map_rst(map_rst),
		.cfg_mir_v(cfg_mir_v),
		.mmc3b_mode(mmc3b_mode),
		.cpu_addr(cpu_addr),
		.cpu_dat(cpu_dat),
		.cpu_ce(cpu_ce),
		.cpu_rw(cpu_rw),
		.ppu_addr(ppu_addr),
		.ppu_oe(ppu_oe),
		.ppu_we(ppu_we),
		.ss_act(ss_act),
		.ss_we(ss_we),
		.ss_addr(ss_addr),
		.prg_addr(prg_addr),
		.prg_oe(prg_oe),
		.rom_ce(rom_ce),
		.ram_ce(ram_ce),
		.ram_we(ram_we),
		.map_cpu_oe(map_cpu_oe),
		.chr_addr(chr_addr),
		.chr_ce(chr_ce),
		.chr_oe(chr_oe),
		.chr_we(chr_we),
		.ciram_a10(ciram_a10),
		.ciram_ce(ciram_ce),
		.irq(irq),
		.ss_rdat(ss_rdat)
	);

	initial
	begin
		m2 = 1'b0;
		forever #10 m2 = ~m2;
	end

	initial
	begin
		#(PLANNED_CYCLES * 20 * 2);
		$display("timeout: the run did not complete in the expected time");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	task automatic check_prg(input prg_addr_t got, input prg_addr_t exp, input string what);
		if (got !== exp)
		begin
			prg_errors++;
			$display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_chr(input chr_addr_t got, input chr_addr_t exp, input string what);
		if (got !== exp)
		begin
			chr_errors++;
			$display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_byte(input bank_t got, input bank_t exp, input string what);
		if (got !== exp)
		begin
			byte_errors++;
			$display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	function automatic prg_bank_t prg_window(input logic [14:0] a);
		logic swap;
		swap = m_regs[0][6];
		case (a[14:13])
			2'd0:    return swap ? 6'h3e : m_bank[6][5:0];
			2'd1:    return m_bank[7][5:0];
			2'd2:    return swap ? m_bank[6][5:0] : 6'h3e;
			default: return 6'h3f;
		endcase
	endfunction

	function automatic bank_t chr_window(input logic [13:0] p);
		bank_t two_kb;
		if (p[12] == m_regs[0][7])
		begin
			two_kb = p[11] ? m_bank[1] : m_bank[0];
			return {two_kb[7:1], p[10]};
		end
		return m_bank[2 + p[11:10]];
	endfunction

	function automatic chr_addr_t chr_expect(input logic [13:0] p);
		bank_t b;
		b = chr_window(p);
		if (b[6])
			b = b & ((MAP_IDX == 119) ? 8'h07 : 8'h01); // ram bank width
		return {b, p[9:0]};
	endfunction

	function automatic bank_t ss_expect(input logic [7:0] a);
		if (a < 8)
			return m_regs[a[2:0]];
		if (a < 16)
			return m_bank[a[2:0]];
		if (a == SS_IRQ_CTR)
			return m_ctr;
		if (a == SS_IRQ_FLAGS)
			return {3'b000, m_on, m_pend, 1'b0, m_req, 1'b0};
		if (a == SS_MAP_IDX)
			return bank_t'(MAP_IDX);
		return 8'hff;
	endfunction

	task automatic cpu_write(input logic [2:0] slot, input bank_t d);
		logic [14:0] a;
		a = 15'($urandom);
		a[14:13] = slot[2:1];
		a[0] = slot[0];
		@(posedge m2);
		cpu_ce <= 1'b0;
		cpu_rw <= 1'b0;
		cpu_addr <= a;
		cpu_dat <= d;
		ss_act <= 1'b0;
		if (slot == 3'd1)
			m_bank[m_regs[0][2:0]] = d; // target picked by $8000
		m_regs[slot] = d;
		case (slot)
			3'd5: m_req = 1'b1;
			3'd6:
			begin
				m_on = 1'b0;
				m_pend = 1'b0;
			end
			3'd7: m_on = 1'b1;
			default: ;
		endcase
	endtask

	task automatic map_check(input logic [14:0] a, input logic [13:0] p, input logic we);
		bank_t b;
		logic  oe;
		oe = 1'($urandom);
		@(posedge m2);
		cpu_ce <= 1'b0;
		cpu_rw <= 1'b1;
		cpu_addr <= a;
		ppu_addr <= p;
		ppu_oe <= oe;
		ppu_we <= we;
		ss_act <= 1'b0;
		#5;
		b = chr_window(p);
		check_prg(prg_addr, {prg_window(a), a[12:0]}, "prg_addr");
		check_byte(bank_t'(rom_ce), 8'd1, "rom_ce");
		check_byte(bank_t'(prg_oe), 8'd1, "prg_oe");
		check_chr(chr_addr, chr_expect(p), "chr_addr");
		check_byte(bank_t'(chr_we), bank_t'(b[6] && !p[13] && !we), "chr_we");
		check_byte(bank_t'(chr_ce), bank_t'(!p[13]), "chr_ce");
		check_byte(bank_t'(chr_oe), bank_t'(!oe), "chr_oe");
		check_byte(bank_t'(ciram_ce), bank_t'(!p[13]), "ciram_ce"); // active low, nametables
		check_byte(bank_t'(ciram_a10), bank_t'(m_regs[2][0] ? p[11] : p[10]), "ciram_a10");
	endtask

	task automatic ram_access(input logic rw);
		logic on;
		logic prot;
		on = m_regs[3][7];
		prot = m_regs[3][6];
		@(posedge m2);
		cpu_ce <= 1'b1;
		cpu_rw <= rw;
		cpu_addr <= {2'b11, 13'($urandom)};
		#5;
		check_byte(bank_t'(rom_ce), 8'd0, "rom_ce");
		check_byte(bank_t'(prg_oe), bank_t'(rw), "prg_oe");
		check_byte(bank_t'(ram_ce), bank_t'(on), "ram_ce");
		check_byte(bank_t'(ram_we), bank_t'(on && !rw && !prot), "ram_we");
		check_byte(bank_t'(map_cpu_oe), bank_t'(!on && rw), "map_cpu_oe");
	endtask

	task automatic ppu_step(input logic a12, input logic rise);
		logic reload;
		logic fire;
		@(posedge m2);
		cpu_ce <= 1'b1;
		cpu_rw <= 1'b1;
		ppu_addr <= {1'b0, a12, 12'h000};
		#5;
		reload = m_req || (mmc3b_mode && m_ctr == 8'd0);
		fire = rise && m_on && (reload ? m_regs[4] == 8'd0 : m_ctr == 8'd1);
		check_byte(bank_t'(irq), bank_t'(m_pend || fire), "irq");
		if (rise)
		begin
			m_ctr = (reload || m_ctr == 8'd0) ? m_regs[4] : m_ctr - 8'd1;
			m_req = 1'b0;
			if (fire)
				m_pend = 1'b1;
		end
	endtask

	task automatic a12_pulse(input int low_cycles);
		repeat (low_cycles) ppu_step(1'b0, 1'b0);
		ppu_step(1'b1, low_cycles >= A12_QUIET);
	endtask

	task automatic ss_read(input logic [7:0] a);
		@(posedge m2);
		ss_act <= 1'b1;
		ss_we <= 1'b0;
		ss_addr <= a;
		#5;
		check_byte(ss_rdat, ss_expect(a), $sformatf("save-state slot %0d", a));
	endtask

	task automatic ss_write(input logic [7:0] a, input bank_t d);
		@(posedge m2);
		ss_act <= 1'b1;
		ss_we <= 1'b1;
		ss_addr <= a;
		cpu_dat <= d;
		if (a < 8)
			m_regs[a[2:0]] = d;
		else if (a < 16)
			m_bank[a[2:0]] = d;
		else if (a == SS_IRQ_FLAGS)
		begin
			m_req = d[1] ^ d[0];
			m_pend = d[3] ^ d[2];
			m_on = d[4];
		end
	endtask

	task automatic ss_read_all();
		for (int s = 0; s < 18; s++)
			ss_read(8'(s));
		ss_read(SS_MAP_IDX);
		ss_read(8'd18);
		ss_read(8'd64);
		ss_read(8'd200);
	endtask

	task automatic irq_run(input logic mode);
		int n;
		n = $urandom_range(1, 20);
		@(posedge m2);
		mmc3b_mode <= mode;
		ppu_addr <= '0;
		cpu_write(3'd4, bank_t'(n));
		cpu_write(3'd5, bank_t'($urandom));
		cpu_write(3'd7, bank_t'($urandom));
		for (int k = 0; k < n + 1; k++)
		begin
			a12_pulse($urandom_range(A12_QUIET, A12_QUIET + 2));
			if ($urandom_range(0, 2) == 0)
				a12_pulse($urandom_range(1, A12_QUIET - 1)); // too short to count
		end
		ppu_step(1'b0, 1'b0);
		check_byte(bank_t'(irq), 8'd1, "irq after reload plus one rises");
		for (int k = 0; k < 3; k++)
			a12_pulse(A12_QUIET);
		cpu_write(3'd6, bank_t'($urandom));
		ppu_step(1'b0, 1'b0);
		check_byte(bank_t'(irq), 8'd0, "irq after disable");

		// run down to zero with a zero reload, then one more rise
		cpu_write(3'd4, 8'd0);
		cpu_write(3'd7, bank_t'($urandom));
		for (int k = 0; k < 24; k++)
			a12_pulse(A12_QUIET);
		cpu_write(3'd6, bank_t'($urandom));
		cpu_write(3'd7, bank_t'($urandom));
		a12_pulse(A12_QUIET);
		check_byte(bank_t'(irq), bank_t'(mode), "irq on a rise at zero with zero reload");
		cpu_write(3'd6, bank_t'($urandom));
	endtask

	initial
	begin
		void'($urandom(SEED));
		prg_errors = 0;
		chr_errors = 0;
		byte_errors = 0;
		map_rst = 1'b1;
		cfg_mir_v = 1'b1;
		mmc3b_mode = 1'b0;
		cpu_addr = '0;
		cpu_dat = '0;
		cpu_ce = 1'b1;
		cpu_rw = 1'b1;
		ppu_addr = '0;
		ppu_oe = 1'b1;
		ppu_we = 1'b1;
		ss_act = 1'b0;
		ss_we = 1'b0;
		ss_addr = '0;
		for (int i = 0; i < 8; i++)
		begin
			m_regs[i] = (i == 2) ? bank_t'(cfg_mir_v) : 8'd0;
			m_bank[i] = BANK_RESET[i];
		end
		m_ctr = '0;
		m_on = 1'b0;
		m_pend = 1'b0;
		m_req = 1'b0;
		repeat (16) @(posedge m2);
		map_rst <= 1'b0;

		// reset mapping
		map_check(15'h0123, 14'h0000, 1'b1);
		map_check(15'h2123, 14'h0c00, 1'b1);
		map_check(15'h4123, 14'h1400, 1'b1);
		map_check(15'h6123, 14'h1c00, 1'b1);
		check_prg(prg_addr, {6'h3f, 13'h0123}, "reset prg window at $e000");
		check_byte(bank_t'(irq), 8'd0, "irq after reset");
		ram_access(1'b1);

		for (int i = 0; i < 300; i++)
		begin
			cpu_write(3'($urandom_range(0, 3)), bank_t'($urandom));
			map_check(15'($urandom), 14'($urandom), 1'($urandom));
		end

		for (int c = 0; c < 4; c++)
		begin
			cpu_write(3'd3, {c[1], c[0], 6'($urandom)});
			repeat (20) ram_access(1'($urandom));
		end

		irq_run(1'b0);
		irq_run(1'b1);

		ss_read_all();
		for (int s = 0; s < 16; s++)
			ss_write(8'(s), bank_t'($urandom));
		ss_write(SS_IRQ_FLAGS, bank_t'($urandom));
		ss_read_all();
		@(posedge m2);
		ss_act <= 1'b0;
		ss_we <= 1'b0;
		ppu_step(1'b0, 1'b0);
		repeat (40) map_check(15'($urandom), 14'($urandom), 1'($urandom));

		@(posedge m2);
		cpu_ce <= 1'b1;
		cpu_rw <= 1'b1;
		$display("errors: prg %0d, chr %0d, byte %0d", prg_errors, chr_errors, byte_errors);
		if (prg_errors + chr_errors + byte_errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
verilog/map_pkg.sv
verilog/mmc3_regs.sv
verilog/mmc3_prg_map.sv
verilog/mmc3_chr_map.sv
verilog/mmc3_irq.sv
verilog/map_119.sv
tests/tb_map_119.sv

// File: Bender.yml
package:
  name: map_119

sources:
  - verilog/map_pkg.sv
  - verilog/mmc3_regs.sv
  - verilog/mmc3_prg_map.sv
  - verilog/mmc3_chr_map.sv
  - verilog/mmc3_irq.sv
  - verilog/map_119.sv
  - target: test
    files:
      - tests/tb_map_119.sv
